// ==== common/ntm_logistic_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared definitions for the vector logistic block
// Q8.8 fixed-point types, PLAN sigmoid breakpoints and offsets,
// control FSM states and the operand bundle fed to the reducer
//////////////////////////////////////////////////////////////////////

package ntm_logistic_pkg;

  // Signed Q8.8 word, also used for unsigned values of the same width
  typedef logic [15:0] fixed_t;

  // Element index and vector size
  typedef logic [15:0] index_t;

  //////////////////////////////////////////////////////////////////////
  // Fixed-point constants
  //////////////////////////////////////////////////////////////////////

  localparam int     FRAC_BITS = 8;
  localparam fixed_t FIX_ONE   = 16'd256;
  localparam fixed_t FIX_HALF  = 16'd128;

  // Segment limits on the magnitude of x
  localparam fixed_t BP_ONE = 16'd256;
  // 2.375
  localparam fixed_t BP_MID = 16'd608;
  // 5.0, saturation
  localparam fixed_t BP_SAT = 16'd1280;

  // Segment offsets, 0.5 / 0.625 / 0.84375
  localparam fixed_t OFS_LOW  = 16'd128;
  localparam fixed_t OFS_MID  = 16'd160;
  localparam fixed_t OFS_HIGH = 16'd216;

  //////////////////////////////////////////////////////////////////////
  // Control types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_INPUT = 2'd1,
    ST_WAIT  = 2'd2
  } logistic_state_t;

  // One reduction job
  typedef struct packed {
    fixed_t value;
    fixed_t modulo;
  } red_operand_t;

endpackage

// ==== rtl/ntm_index_counter.sv ====
//////////////////////////////////////////////////////////////////////
// Element index counter
// Latches the vector size at start and flags the last element
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ntm_index_counter (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     count_clear,
  input  logic                     count_step,
  input  ntm_logistic_pkg::index_t size,
  output logic                     last
);

  import ntm_logistic_pkg::*;

  index_t index;
  index_t size_q;
  index_t last_index;

  // Index and latched size
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index  <= '0;
      size_q <= '0;
    end else if (count_clear) begin
      index  <= '0;
      size_q <= size;
    end else if (count_step) begin
      index <= index + index_t'(1);
    end
  end

  // Size of zero never sent by the source
  assign last_index = size_q - index_t'(1);

  // Level, high while the final element is in flight
  assign last = (index == last_index);

endmodule

// ==== rtl/ntm_logistic_ctrl_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// Control FSM of the vector logistic block
// Accepts a vector start, admits one element at a time, waits for
// the reducer and raises the output strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ntm_logistic_ctrl_fsm (
  input  logic CLK,
  input  logic RST,
  input  logic START,
  input  logic DATA_IN_ENABLE,
  input  logic last,
  input  logic done,
  output logic load,
  output logic count_clear,
  output logic count_step,
  output logic READY,
  output logic DATA_OUT_ENABLE
);

  import ntm_logistic_pkg::*;

  logistic_state_t state;
  logistic_state_t state_next;

  //////////////////////////////////////////////////////////////////////
  // Combinational strobes
  //////////////////////////////////////////////////////////////////////

  // Counter restarts in the cycle START is taken, SIZE_IN sampled there
  assign count_clear = (state == ST_IDLE) && START;

  // Element handed to the reducer in the same cycle
  assign load = (state == ST_INPUT) && DATA_IN_ENABLE;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (START) begin
          state_next = ST_INPUT;
        end
      end
      ST_INPUT: begin
        // Strobes elsewhere are dropped
        if (DATA_IN_ENABLE) begin
          state_next = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (done) begin
          // Loop again or close the vector
          state_next = last ? ST_IDLE : ST_INPUT;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and registered pulses
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ST_IDLE;
      count_step      <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
    end else begin
      state <= state_next;
      // Pulses last one cycle by default
      count_step      <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      if ((state == ST_WAIT) && done) begin
        DATA_OUT_ENABLE <= 1'b1;
        // Final element ends the vector
        READY      <= last;
        count_step <= !last;
      end
    end
  end

endmodule

// ==== rtl/ntm_vector_logistic_function.sv ====
//////////////////////////////////////////////////////////////////////
// Vector logistic block, top level
// Applies the PLAN sigmoid to each element of a vector and reduces
// the result modulo MODULO_IN, one element in flight at a time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ntm_vector_logistic_function (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  ntm_logistic_pkg::index_t SIZE_IN,
  input  logic                     DATA_IN_ENABLE,
  input  ntm_logistic_pkg::fixed_t DATA_IN,
  input  ntm_logistic_pkg::fixed_t MODULO_IN,
  output logic                     READY,
  output logic                     DATA_OUT_ENABLE,
  output ntm_logistic_pkg::fixed_t DATA_OUT
);

  import ntm_logistic_pkg::*;

  // FSM to counter
  logic count_clear;
  logic count_step;
  logic last;

  // FSM to reducer
  logic load;
  logic done;

  // Datapath
  fixed_t       sigma;
  red_operand_t operand;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  ntm_logistic_ctrl_fsm i_ctrl_fsm (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .last            (last),
    .done            (done),
    .load            (load),
    .count_clear     (count_clear),
    .count_step      (count_step),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE)
  );

  ntm_index_counter i_index_counter (
    .CLK         (CLK),
    .RST         (RST),
    .count_clear (count_clear),
    .count_step  (count_step),
    .size        (SIZE_IN),
    .last        (last)
  );

  //////////////////////////////////////////////////////////////////////
  // Scalar datapath
  //////////////////////////////////////////////////////////////////////

  ntm_plan_sigmoid i_plan_sigmoid (
    .x     (DATA_IN),
    .sigma (sigma)
  );

  // Sampled by the reducer on load
  assign operand.value  = sigma;
  assign operand.modulo = MODULO_IN;

  ntm_modular_reducer i_modular_reducer (
    .CLK     (CLK),
    .RST     (RST),
    .load    (load),
    .operand (operand),
    .result  (DATA_OUT),
    .done    (done)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the vector logistic testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module ntm_vector_logistic_tb -f tb.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

# Keep running after an assertion error so the testbench can report
./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== scalar_logistic/ntm_modular_reducer.sv ====
//////////////////////////////////////////////////////////////////////
// Modular reduction of a sigmoid value by repeated subtraction
// Latches the operand on load, pulses done when the remainder is
// below the modulus, result held until the next load
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ntm_modular_reducer (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           load,
  input  ntm_logistic_pkg::red_operand_t operand,
  output ntm_logistic_pkg::fixed_t       result,
  output logic                           done
);

  import ntm_logistic_pkg::*;

  // Working copy of the job
  red_operand_t work;
  logic         busy;
  logic         finished;

  // Zero modulus means no reduction
  assign finished = (work.modulo == '0) || (work.value < work.modulo);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= 1'b0;
      if (load) begin
        busy <= 1'b1;
      end else if (busy && finished) begin
        // One cycle after the remainder drops below the modulus
        busy   <= 1'b0;
        done   <= 1'b1;
        result <= work.value;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (load) begin
      work <= operand;
    end else if (busy && !finished) begin
      // One subtraction per cycle
      work.value <= work.value - work.modulo;
    end
  end

endmodule

// ==== scalar_logistic/ntm_plan_sigmoid.sv ====
//////////////////////////////////////////////////////////////////////
// PLAN sigmoid approximation of one Q8.8 element
// Purely combinational, result lies between 0 and 1.0 (256)
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ntm_plan_sigmoid (
  input  ntm_logistic_pkg::fixed_t x,
  output ntm_logistic_pkg::fixed_t sigma
);

  import ntm_logistic_pkg::*;

  fixed_t mag;
  fixed_t pos_sigma;
  logic   neg;

  assign neg = x[15];

  // Magnitude, -32768 stays 0x8000 and saturates below
  assign mag = neg ? (~x + fixed_t'(1)) : x;

  //////////////////////////////////////////////////////////////////////
  // Segment select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (mag < BP_ONE) begin
      // |x| < 1.0, slope 1/4
      pos_sigma = (mag >> 2) + OFS_LOW;
    end else if (mag < BP_MID) begin
      // 1.0 <= |x| < 2.375, slope 1/8
      pos_sigma = (mag >> 3) + OFS_MID;
    end else if (mag < BP_SAT) begin
      // 2.375 <= |x| < 5.0, slope 1/32
      pos_sigma = (mag >> 5) + OFS_HIGH;
    end else begin
      pos_sigma = FIX_ONE;
    end
  end

  // Symmetry about 0.5
  assign sigma = neg ? (FIX_ONE - pos_sigma) : pos_sigma;

endmodule

// ==== tb.f ====
common/ntm_logistic_pkg.sv
rtl/ntm_logistic_ctrl_fsm.sv
rtl/ntm_index_counter.sv
scalar_logistic/ntm_plan_sigmoid.sv
scalar_logistic/ntm_modular_reducer.sv
rtl/ntm_vector_logistic_function.sv
verification/ntm_vector_logistic_sva.sv
verification/ntm_vector_logistic_tb.sv

// ==== verification/ntm_vector_logistic_sva.sv ====
//////////////////////////////////////////////////////////////////////
// Protocol assertions on the vector logistic top level
// Bound into the DUT, checks the output strobes and the remainder
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ntm_vector_logistic_sva (
  input logic                     CLK,
  input logic                     RST,
  input logic                     READY,
  input logic                     DATA_OUT_ENABLE,
  input ntm_logistic_pkg::fixed_t DATA_OUT,
  input ntm_logistic_pkg::fixed_t MODULO_IN
);

  // Failures seen so far, read by the testbench
  int fail_count;

  initial fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Strobe shape
  //////////////////////////////////////////////////////////////////////

  a_doe_pulse: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else begin
      $error("DATA_OUT_ENABLE high for two cycles in a row");
      fail_count++;
    end

  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY)
    else begin
      $error("READY high for two cycles in a row");
      fail_count++;
    end

  // READY marks the last output only
  a_ready_with_out: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else begin
      $error("READY high without DATA_OUT_ENABLE");
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge CLK)
    RST |-> (!READY && !DATA_OUT_ENABLE))
    else begin
      $error("output strobe high during reset");
      fail_count++;
    end

  // Remainder below a nonzero modulus
  a_remainder: assert property (@(posedge CLK) disable iff (RST)
    (DATA_OUT_ENABLE && (MODULO_IN != '0)) |-> (DATA_OUT < MODULO_IN))
    else begin
      $error("DATA_OUT not below MODULO_IN at an output strobe");
      fail_count++;
    end

endmodule

bind ntm_vector_logistic_function ntm_vector_logistic_sva i_sva (
  .CLK             (CLK),
  .RST             (RST),
  .READY           (READY),
  .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
  .DATA_OUT        (DATA_OUT),
  .MODULO_IN       (MODULO_IN)
);

// ==== verification/ntm_vector_logistic_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the vector logistic block
// Drives single-element and multi-element vectors, checks every
// output against a reference of the PLAN and modulo rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ntm_vector_logistic_tb;

  import ntm_logistic_pkg::*;

  // Worst case is sigma 256 with modulus 1
  localparam int OUT_TIMEOUT  = 400;
  localparam int QUIET_CYCLES = 6;

  logic   CLK;
  logic   RST;
  logic   START;
  index_t SIZE_IN;
  logic   DATA_IN_ENABLE;
  fixed_t DATA_IN;
  fixed_t MODULO_IN;
  logic   READY;
  logic   DATA_OUT_ENABLE;
  fixed_t DATA_OUT;

  logic [31:0] lfsr;
  string       test_name;
  int          value_errors;
  int          timeout_errors;
  int          protocol_errors;
  int          outputs;

  // Current vector, one entry per element
  fixed_t vec_x[$];
  fixed_t vec_mod[$];
  fixed_t points [20];
  fixed_t moduli [4];

  ntm_vector_logistic_function i_dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .MODULO_IN       (MODULO_IN),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  // Every output strobe, counted apart from the waits
  always @(posedge CLK) begin
    if (DATA_OUT_ENABLE) begin
      outputs++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic fixed_t random_bits(input int n);
    fixed_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // Segments on |x|, mirrored about 0.5 for negative x
  function automatic fixed_t plan_ref(input fixed_t x);
    int xs;
    int mag;
    int p;
    xs  = int'($signed(x));
    mag = (xs < 0) ? -xs : xs;
    if (mag < 256) begin
      p = mag / 4 + 128;
    end else if (mag < 608) begin
      p = mag / 8 + 160;
    end else if (mag < 1280) begin
      p = mag / 32 + 216;
    end else begin
      p = 256;
    end
    return (xs < 0) ? 16'(256 - p) : 16'(p);
  endfunction

  // Zero modulus leaves the value alone
  function automatic fixed_t mod_ref(input fixed_t v, input fixed_t m);
    if (m == '0) begin
      return v;
    end
    return 16'(int'(v) % int'(m));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input int idx,
                             input fixed_t expected, input fixed_t actual);
    assert (actual == expected) else begin
      $display("ERR %s %s element %0d: expected %0d, actual %0d",
               test_name, what, idx, expected, actual);
      value_errors++;
    end
  endtask

  // No strobe may show up while idle
  task automatic expect_idle();
    repeat (QUIET_CYCLES) begin
      @(negedge CLK);
      assert (!READY && !DATA_OUT_ENABLE) else begin
        $display("%s: output strobe seen while no element was in flight", test_name);
        protocol_errors++;
      end
    end
  endtask

  task automatic wait_output(input int idx, input fixed_t expected, input logic is_last);
    int  cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < OUT_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
      seen = DATA_OUT_ENABLE;
    end
    if (!seen) begin
      $display("%s: no DATA_OUT_ENABLE for element %0d within %0d cycles",
               test_name, idx, OUT_TIMEOUT);
      timeout_errors++;
    end else begin
      check_value("DATA_OUT", idx, expected, DATA_OUT);
      // READY only with the final output
      check_value("READY", idx, {15'd0, is_last}, {15'd0, READY});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic start_vector(input int n);
    @(negedge CLK);
    START   = 1'b1;
    SIZE_IN = 16'(n);
    @(negedge CLK);
    START = 1'b0;
  endtask

  // Noisy mode holds the strobe a second cycle and adds a stray START
  task automatic send_element(input fixed_t x, input fixed_t m, input logic noisy);
    @(negedge CLK);
    DATA_IN        = x;
    MODULO_IN      = m;
    DATA_IN_ENABLE = 1'b1;
    @(negedge CLK);
    if (noisy) begin
      DATA_IN = ~x;
      START   = 1'b1;
      SIZE_IN = 16'd3;
      @(negedge CLK);
      START = 1'b0;
    end
    DATA_IN_ENABLE = 1'b0;
  endtask

  task automatic run_vector(input logic noisy);
    int n;
    int first;
    n     = vec_x.size();
    first = outputs;
    start_vector(n);
    for (int k = 0; k < n; k++) begin
      send_element(vec_x[k], vec_mod[k], noisy);
      wait_output(k, mod_ref(plan_ref(vec_x[k]), vec_mod[k]), k == n - 1);
    end
    expect_idle();
    // Exactly one output strobe per element
    assert (outputs - first == n) else begin
      $display("ERR %s output count: expected %0d, actual %0d",
               test_name, n, outputs - first);
      value_errors++;
    end
  endtask

  task automatic fill_random(input int n);
    fixed_t r;
    vec_x.delete();
    vec_mod.delete();
    for (int i = 0; i < n; i++) begin
      // 12 bits sign-extended reach every segment
      r = random_bits(12);
      vec_x.push_back({{4{r[11]}}, r[11:0]});
      r = random_bits(6);
      vec_mod.push_back(r + 16'd1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int total;
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    SIZE_IN        = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN        = '0;
    MODULO_IN      = '0;
    lfsr           = 32'hcffaf15e;
    value_errors    = 0;
    timeout_errors  = 0;
    protocol_errors = 0;
    outputs         = 0;
    // Segment interiors and exact breakpoints, both signs
    points = '{16'd0, 16'd1, 16'd100, 16'd255, 16'd256, 16'd257, 16'd400,
               16'd607, 16'd608, 16'd900, 16'd1279, 16'd1280, 16'd5000,
               16'd32767, -16'd1, -16'd100, -16'd256, -16'd608, -16'd1280,
               -16'd32768};
    moduli = '{16'd1, 16'd7, 16'd100, 16'd0};

    test_name = "reset";
    repeat (10) begin
      @(negedge CLK);
      assert (!READY && !DATA_OUT_ENABLE) else begin
        $display("reset: output strobe high while RST was asserted");
        protocol_errors++;
      end
    end
    RST = 1'b0;
    check_value("DATA_OUT", 0, 16'd0, DATA_OUT);
    expect_idle();

    test_name = "plan_segments";
    foreach (points[i]) begin
      vec_x   = '{points[i]};
      vec_mod = '{16'd1000};
      run_vector(1'b0);
    end

    test_name = "modular_reduction";
    foreach (moduli[j]) begin
      foreach (points[i]) begin
        vec_x   = '{points[i]};
        vec_mod = '{moduli[j]};
        run_vector(1'b0);
      end
    end

    test_name = "vector_loop";
    fill_random(8);
    run_vector(1'b0);

    test_name = "ignored_strobes";
    fill_random(8);
    run_vector(1'b1);

    // Clean vector after the stray strobes
    test_name = "restart";
    fill_random(4);
    run_vector(1'b0);

    total = value_errors + timeout_errors + protocol_errors + i_dut.i_sva.fail_count;
    $display("value errors %0d, timeouts %0d, protocol errors %0d, assertion errors %0d",
             value_errors, timeout_errors, protocol_errors, i_dut.i_sva.fail_count);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
